// File: hdl/axi_wr_pkg.sv
// AXI write path package: channel field widths, item structs and response codes
package axi_wr_pkg;

  //////////////////////////////////////////////////
  // Field widths and scalar types

  localparam int ID_W   = 4;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ID_W-1:0]     id_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] strb_t;
  typedef logic [7:0]          len_t;
  typedef logic [2:0]          size_t;
  typedef logic [1:0]          burst_t;
  typedef logic [1:0]          resp_t;

  // Response codes carried on B
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  //////////////////////////////////////////////////
  // Channel items

  // Write address, 49 bits
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } aw_t;

  // Write data beat, 41 bits
  typedef struct packed {
    id_t   id;
    data_t data;
    strb_t strb;
    logic  last;
  } w_t;

  // Write response, 6 bits
  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_t;

endpackage

// File: hdl/link_pkg.sv
// Logic link package: PHY lane word layouts, receive payload union and item kinds
package link_pkg;

  localparam int LINK_W = 80;
  localparam int CRED_W = 8;

  // Selects how the receive payload is read
  typedef enum logic {
    KIND_AW = 1'b0,
    KIND_W  = 1'b1
  } kind_t;

  // W beat padded up to the AW item size
  typedef struct packed {
    axi_wr_pkg::w_t w;
    logic [7:0]     spare;
  } w_pad_t;

  typedef union packed {
    axi_wr_pkg::aw_t aw;
    w_pad_t          w;
  } rx_payload_u;

  localparam int RX_SPARE_W = LINK_W - 3 - $bits(rx_payload_u);
  localparam int TX_SPARE_W = LINK_W - 3 - $bits(axi_wr_pkg::b_t);

  // Master to slave
  typedef struct packed {
    logic                  push;
    kind_t                 kind;
    logic                  b_credit;
    logic [RX_SPARE_W-1:0] spare;
    rx_payload_u           payload;
  } rx_word_t;

  // Slave to master
  typedef struct packed {
    logic                  push;
    logic                  aw_credit;
    logic                  w_credit;
    logic [TX_SPARE_W-1:0] spare;
    axi_wr_pkg::b_t        b;
  } tx_word_t;

endpackage

// File: hdl/link_rx_decode.sv
// Receive word decode: registers the PHY word and splits it into AW push, W push and B credit
module link_rx_decode (
  input  logic                clk_wr,
  input  logic                reset,
  input  logic                rx_online,
  input  link_pkg::rx_word_t  rx_phy,
  output logic                aw_push,
  output axi_wr_pkg::aw_t     aw_item,
  output logic                w_push,
  output axi_wr_pkg::w_t      w_item,
  output logic                b_credit_pulse
);
  import link_pkg::*;

  logic        push_q;
  kind_t       kind_q;
  logic        b_credit_q;
  rx_payload_u payload_q;

  // Control bits, dropped while the lane is offline
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      push_q     <= 1'b0;
      kind_q     <= KIND_AW;
      b_credit_q <= 1'b0;
    end else begin
      push_q     <= rx_online & rx_phy.push;
      kind_q     <= rx_phy.kind;
      b_credit_q <= rx_online & rx_phy.b_credit;
    end
  end

  // Payload only moves on an accepted push
  always_ff @(posedge clk_wr) begin
    if (rx_online && rx_phy.push) begin
      payload_q <= rx_phy.payload;
    end
  end

  // Kind bit steers the push and picks the union view
  assign aw_push        = push_q & (kind_q == KIND_AW);
  assign w_push         = push_q & (kind_q == KIND_W);
  assign aw_item        = payload_q.aw;
  assign w_item         = payload_q.w.w;
  assign b_credit_pulse = b_credit_q;

endmodule

// File: hdl/ll_receive.sv
// Credited receive FIFO: buffers pushed link items and returns a credit on each user pop
module ll_receive #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = 8
) (
  input  logic  clk_wr,
  input  logic  reset,
  input  logic  push,
  input  item_t push_item,
  output logic  valid,
  output item_t item,
  input  logic  ready,
  output logic  credit_pulse
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full  = (count == CNT_W'(DEPTH));
  assign rd_en = valid & ready;
  // A push into a full FIFO is lost unless the head leaves this cycle
  assign wr_en = push & (~full | rd_en);

  //////////////////////////////////////////////////
  // Pointers and occupancy

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_item;
    end
  end

  //////////////////////////////////////////////////
  // User side and credit return

  assign valid        = (count != '0);
  assign item         = mem[rd_ptr];
  assign credit_pulse = rd_en;

endmodule

// File: hdl/ll_transmit.sv
// B transmit credit counter: tracks credits granted by the master and gates user_bready
module ll_transmit (
  input  logic                        clk_wr,
  input  logic                        reset,
  input  logic                        tx_online,
  input  logic [link_pkg::CRED_W-1:0] init_b_credit,
  input  logic                        b_credit_pulse,
  input  logic                        user_bvalid,
  output logic                        user_bready
);
  import link_pkg::*;

  logic [CRED_W-1:0] credit_q;
  logic              b_fire;

  // One credit per response on the lane
  assign user_bready = tx_online & (credit_q != '0);
  assign b_fire      = user_bvalid & user_bready;

  //////////////////////////////////////////////////
  // Credit count

  // Initial grant is reloaded on every reset cycle
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit_q <= init_b_credit;
    end else begin
      case ({b_fire, b_credit_pulse})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        // Spend and refill together cancel out
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

// File: hdl/link_tx_encode.sv
// Transmit word encode: packs the B item and the returned credits into the registered PHY word
module link_tx_encode (
  input  logic                clk_wr,
  input  logic                reset,
  input  logic                b_fire,
  input  axi_wr_pkg::b_t      b_item,
  input  logic                aw_credit,
  input  logic                w_credit,
  output link_pkg::tx_word_t  tx_phy
);
  import link_pkg::*;

  tx_word_t tx_d;

  // Unused fields stay zero
  always_comb begin
    tx_d           = '0;
    tx_d.push      = b_fire;
    tx_d.aw_credit = aw_credit;
    tx_d.w_credit  = w_credit;
    if (b_fire) begin
      tx_d.b = b_item;
    end
  end

  //////////////////////////////////////////////////
  // Lane register

  // Each word lives for a single cycle
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_d;
    end
  end

endmodule

// File: hdl/axi_wr_link_slave.sv
// AXI write link slave top: PHY receive decode, credited FIFOs, B credits and PHY transmit encode
module axi_wr_link_slave #(
  parameter int AW_DEPTH = 8,
  parameter int W_DEPTH  = 16
) (
  input  logic                        clk_wr,
  input  logic                        reset,

  // Link control
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  logic [link_pkg::CRED_W-1:0] init_b_credit,

  // PHY lane
  input  link_pkg::rx_word_t          rx_phy,
  output link_pkg::tx_word_t          tx_phy,

  // AW channel
  output axi_wr_pkg::aw_t             user_aw,
  output logic                        user_awvalid,
  input  logic                        user_awready,

  // W channel
  output axi_wr_pkg::w_t              user_w,
  output logic                        user_wvalid,
  input  logic                        user_wready,

  // B channel
  input  axi_wr_pkg::b_t              user_b,
  input  logic                        user_bvalid,
  output logic                        user_bready
);
  import axi_wr_pkg::*;

  logic aw_push;
  aw_t  aw_item;
  logic w_push;
  w_t   w_item;
  logic b_credit_pulse;
  logic aw_credit;
  logic w_credit;
  logic b_fire;

  assign b_fire = user_bvalid & user_bready;

  //////////////////////////////////////////////////
  // Input side

  link_rx_decode link_rx_decode_i (
    // Outputs
    .aw_push        (aw_push),
    .aw_item        (aw_item),
    .w_push         (w_push),
    .w_item         (w_item),
    .b_credit_pulse (b_credit_pulse),
    // Inputs
    .clk_wr         (clk_wr),
    .reset          (reset),
    .rx_online      (rx_online),
    .rx_phy         (rx_phy)
  );

  //////////////////////////////////////////////////
  // Receive FIFOs and B credits

  ll_receive #(.item_t(aw_t), .DEPTH(AW_DEPTH)) ll_receive_iaw (
    // Outputs
    .valid        (user_awvalid),
    .item         (user_aw),
    .credit_pulse (aw_credit),
    // Inputs
    .clk_wr       (clk_wr),
    .reset        (reset),
    .push         (aw_push),
    .push_item    (aw_item),
    .ready        (user_awready)
  );

  ll_receive #(.item_t(w_t), .DEPTH(W_DEPTH)) ll_receive_iw (
    // Outputs
    .valid        (user_wvalid),
    .item         (user_w),
    .credit_pulse (w_credit),
    // Inputs
    .clk_wr       (clk_wr),
    .reset        (reset),
    .push         (w_push),
    .push_item    (w_item),
    .ready        (user_wready)
  );

  ll_transmit ll_transmit_ib (
    // Outputs
    .user_bready    (user_bready),
    // Inputs
    .clk_wr         (clk_wr),
    .reset          (reset),
    .tx_online      (tx_online),
    .init_b_credit  (init_b_credit),
    .b_credit_pulse (b_credit_pulse),
    .user_bvalid    (user_bvalid)
  );

  //////////////////////////////////////////////////
  // Output side

  link_tx_encode link_tx_encode_i (
    // Outputs
    .tx_phy    (tx_phy),
    // Inputs
    .clk_wr    (clk_wr),
    .reset     (reset),
    .b_fire    (b_fire),
    .b_item    (user_b),
    .aw_credit (aw_credit),
    .w_credit  (w_credit)
  );

endmodule

// File: verif/tb_axi_wr_link_slave.sv
// Testbench for the AXI write link slave: directed tests over the PHY lane and the user channels
module tb_axi_wr_link_slave;
  import axi_wr_pkg::*;
  import link_pkg::*;

  localparam int WAIT_LIMIT = 50;

  logic              clk_wr = 1'b0;
  logic              reset;
  logic              tx_online;
  logic              rx_online;
  logic [CRED_W-1:0] init_b_credit;
  rx_word_t          rx_phy;
  tx_word_t          tx_phy;
  aw_t               user_aw;
  logic              user_awvalid;
  logic              user_awready;
  w_t                user_w;
  logic              user_wvalid;
  logic              user_wready;
  b_t                user_b;
  logic              user_bvalid;
  logic              user_bready;

  integer            seed = 32'ha170;
  tx_word_t          tx_log[$];

  axi_wr_link_slave #(.AW_DEPTH(8), .W_DEPTH(16)) axi_wr_link_slave_i (
    .clk_wr        (clk_wr),
    .reset         (reset),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .init_b_credit (init_b_credit),
    .rx_phy        (rx_phy),
    .tx_phy        (tx_phy),
    .user_aw       (user_aw),
    .user_awvalid  (user_awvalid),
    .user_awready  (user_awready),
    .user_w        (user_w),
    .user_wvalid   (user_wvalid),
    .user_wready   (user_wready),
    .user_b        (user_b),
    .user_bvalid   (user_bvalid),
    .user_bready   (user_bready)
  );

  always #10 clk_wr = ~clk_wr;

  // Every nonzero transmit word, in arrival order
  always @(negedge clk_wr) begin
    if (!reset && tx_phy != '0) begin
      tx_log.push_back(tx_phy);
    end
  end

  //////////////////////////////////////////////////
  // Error reporting and compare tasks

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_aw(input string name, input aw_t got, input aw_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_w(input string name, input w_t got, input w_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_tx(input string name, input tx_word_t got, input tx_word_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic expect_tx_words(input int n, input string what);
    if (tx_log.size() != n) begin
      stop_on_error($sformatf("%s: expected %0d words on tx_phy but saw %0d",
                              what, n, tx_log.size()));
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and expected words

  function automatic aw_t random_aw();
    aw_t         a;
    logic [31:0] r;
    r       = $random(seed);
    a.addr  = r;
    r       = $random(seed);
    a.id    = r[3:0];
    a.len   = r[11:4];
    a.size  = r[14:12];
    a.burst = r[16:15];
    return a;
  endfunction

  function automatic w_t random_w();
    w_t          w;
    logic [31:0] r;
    r      = $random(seed);
    w.data = r;
    r      = $random(seed);
    w.id   = r[3:0];
    w.strb = r[7:4];
    w.last = r[8];
    return w;
  endfunction

  function automatic b_t random_b(input resp_t resp);
    b_t          b;
    logic [31:0] r;
    r      = $random(seed);
    b.id   = r[3:0];
    b.resp = resp;
    return b;
  endfunction

  function automatic rx_word_t aw_word(input aw_t a);
    rx_word_t x;
    x            = '0;
    x.push       = 1'b1;
    x.kind       = KIND_AW;
    x.payload.aw = a;
    return x;
  endfunction

  // Spare bits of the W view carry junk the DUT must ignore
  function automatic rx_word_t w_word(input w_t w);
    rx_word_t x;
    x                 = '0;
    x.push            = 1'b1;
    x.kind            = KIND_W;
    x.payload.w.w     = w;
    x.payload.w.spare = 8'ha5;
    return x;
  endfunction

  function automatic rx_word_t credit_rx_word();
    rx_word_t x;
    x          = '0;
    x.b_credit = 1'b1;
    return x;
  endfunction

  function automatic tx_word_t credit_word(input logic aw_c, input logic w_c);
    tx_word_t t;
    t           = '0;
    t.aw_credit = aw_c;
    t.w_credit  = w_c;
    return t;
  endfunction

  function automatic tx_word_t response_word(input b_t b);
    tx_word_t t;
    t      = '0;
    t.push = 1'b1;
    t.b    = b;
    return t;
  endfunction

  task automatic send_rx(input rx_word_t x);
    @(posedge clk_wr);
    rx_phy <= x;
  endtask

  task automatic clear_rx();
    @(posedge clk_wr);
    rx_phy <= '0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_wr);
  endtask

  task automatic wait_user_valid(input logic want_w, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk_wr);
    while ((want_w ? user_wvalid : user_awvalid) !== 1'b1) begin
      cycles = cycles + 1;
      if (cycles > WAIT_LIMIT) begin
        stop_on_error(what);
      end
      @(negedge clk_wr);
    end
  endtask

  task automatic present_b(input b_t b);
    @(posedge clk_wr);
    user_b      <= b;
    user_bvalid <= 1'b1;
  endtask

  // Valid drops on the edge that completes the handshake
  task automatic wait_b_accept(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk_wr);
    while (user_bready !== 1'b1) begin
      cycles = cycles + 1;
      if (cycles > WAIT_LIMIT) begin
        stop_on_error(what);
      end
      @(negedge clk_wr);
    end
    @(posedge clk_wr);
    user_bvalid <= 1'b0;
  endtask

  task automatic send_b(input b_t b);
    present_b(b);
    wait_b_accept("B response was never accepted by user_bready");
  endtask

  //////////////////////////////////////////////////
  // Directed tests

  task automatic reset_state();
    repeat (2) begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      check_bit("user_awvalid", user_awvalid, 1'b0);
      check_bit("user_wvalid", user_wvalid, 1'b0);
      check_tx("tx_phy", tx_phy, '0);
    end
    @(posedge clk_wr);
    reset <= 1'b0;
    @(negedge clk_wr);
    check_bit("user_awvalid", user_awvalid, 1'b0);
    check_bit("user_wvalid", user_wvalid, 1'b0);
    check_tx("tx_phy", tx_phy, '0);
  endtask

  task automatic aw_transfer();
    aw_t exp_aw;
    exp_aw = random_aw();
    tx_log.delete();
    send_rx(aw_word(exp_aw));
    clear_rx();
    wait_user_valid(1'b0, "AW item never raised user_awvalid");
    check_aw("user_aw", user_aw, exp_aw);
    expect_tx_words(0, "AW credit before the pop");
    @(posedge clk_wr);
    user_awready <= 1'b1;
    @(posedge clk_wr);
    user_awready <= 1'b0;
    @(negedge clk_wr);
    check_bit("user_awvalid", user_awvalid, 1'b0);
    idle(3);
    expect_tx_words(1, "AW credit return");
    check_tx("tx_phy", tx_log[0], credit_word(1'b1, 1'b0));
  endtask

  task automatic w_burst_backpressure();
    w_t beats[4];
    int i;
    tx_log.delete();
    for (i = 0; i < 4; i++) begin
      beats[i] = random_w();
    end
    for (i = 0; i < 4; i++) begin
      send_rx(w_word(beats[i]));
    end
    clear_rx();
    wait_user_valid(1'b1, "W beats never raised user_wvalid");
    idle(4);
    expect_tx_words(0, "W credit while user_wready is low");
    @(posedge clk_wr);
    user_wready <= 1'b1;
    // One beat leaves on each edge while ready stays high
    for (i = 0; i < 4; i++) begin
      @(negedge clk_wr);
      check_bit("user_wvalid", user_wvalid, 1'b1);
      check_w("user_w", user_w, beats[i]);
    end
    @(posedge clk_wr);
    user_wready <= 1'b0;
    @(negedge clk_wr);
    check_bit("user_wvalid", user_wvalid, 1'b0);
    idle(3);
    expect_tx_words(4, "W credit return");
    for (i = 0; i < 4; i++) begin
      check_tx("tx_phy", tx_log[i], credit_word(1'b0, 1'b1));
    end
  endtask

  // Starts with the two credits loaded at reset
  task automatic b_credit_flow();
    b_t b0;
    b_t b1;
    b_t b2;
    b0 = random_b(RESP_OKAY);
    b1 = random_b(RESP_SLVERR);
    b2 = random_b(RESP_OKAY);
    tx_log.delete();
    send_b(b0);
    send_b(b1);
    present_b(b2);
    repeat (4) begin
      @(negedge clk_wr);
      check_bit("user_bready", user_bready, 1'b0);
    end
    send_rx(credit_rx_word());
    clear_rx();
    wait_b_accept("third B response was never accepted after the credit");
    idle(3);
    expect_tx_words(3, "B responses");
    check_tx("tx_phy", tx_log[0], response_word(b0));
    check_tx("tx_phy", tx_log[1], response_word(b1));
    check_tx("tx_phy", tx_log[2], response_word(b2));
  endtask

  task automatic online_gating();
    b_t b;
    b = random_b(RESP_SLVERR);
    tx_log.delete();
    @(posedge clk_wr);
    rx_online <= 1'b0;
    send_rx(aw_word(random_aw()));
    send_rx(w_word(random_w()));
    clear_rx();
    repeat (6) begin
      @(negedge clk_wr);
      check_bit("user_awvalid", user_awvalid, 1'b0);
      check_bit("user_wvalid", user_wvalid, 1'b0);
    end
    @(posedge clk_wr);
    rx_online <= 1'b1;
    // Grant one credit, then take the transmit lane offline
    send_rx(credit_rx_word());
    clear_rx();
    tx_online <= 1'b0;
    present_b(b);
    repeat (5) begin
      @(negedge clk_wr);
      check_bit("user_bready", user_bready, 1'b0);
    end
    expect_tx_words(0, "traffic while offline");
    @(posedge clk_wr);
    tx_online <= 1'b1;
    wait_b_accept("B response was never accepted after tx_online rose");
    idle(3);
    expect_tx_words(1, "B response after tx_online");
    check_tx("tx_phy", tx_log[0], response_word(b));
  endtask

  initial begin
    reset         = 1'b1;
    tx_online     = 1'b1;
    rx_online     = 1'b1;
    init_b_credit = 8'd2;
    rx_phy        = '0;
    user_awready  = 1'b0;
    user_wready   = 1'b0;
    user_b        = '0;
    user_bvalid   = 1'b0;

    reset_state();
    aw_transfer();
    w_burst_backpressure();
    b_credit_flow();
    online_gating();

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: all.f
hdl/axi_wr_pkg.sv
hdl/link_pkg.sv
hdl/link_rx_decode.sv
hdl/ll_receive.sv
hdl/ll_transmit.sv
hdl/link_tx_encode.sv
hdl/axi_wr_link_slave.sv
verif/tb_axi_wr_link_slave.sv

// File: run.sh
#!/bin/sh
verilator --binary -j 0 --top-module tb_axi_wr_link_slave -f all.f \
  && ./obj_dir/Vtb_axi_wr_link_slave | tee /dev/stderr | grep -q -x ">>> PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
